/* busMapPkg.sv */
// CPU-side address map and request format of the data bus.
// The bridges classify byte addresses with these windows.
// Reference items by scoped name, e.g. busMapPkg::cpuReqT.

`default_nettype none

package busMapPkg;

    // Data memory byte window, end exclusive
    localparam logic [31:0] DataStart = 32'h0000_0000;
    localparam logic [31:0] DataEnd = 32'h0000_3000;

    // Timer windows, three registers each
    localparam logic [31:0] Timer0Start = 32'h0000_7F00;
    localparam logic [31:0] Timer0End = 32'h0000_7F0C;
    localparam logic [31:0] Timer1Start = 32'h0000_7F10;
    localparam logic [31:0] Timer1End = 32'h0000_7F1C;

    // Decoded target of a request
    typedef enum logic [1:0] {
        regionNone,
        regionData,
        regionTimer0,
        regionTimer1
    } regionE;

    // One request from the CPU data port
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] wData;
        logic [3:0] we;
    } cpuReqT;

    // Half-open window test on a byte address
    function automatic logic inWindow(
        input logic [31:0] addr,
        input logic [31:0] startAddr,
        input logic [31:0] endAddr
    );
        return (addr >= startAddr) && (addr < endAddr);
    endfunction

endpackage

`default_nettype wire

/* devicePkg.sv */
// Device-side request format and the countdown timer register layout.
// Shared by the south bridge, the timers and the bound assertions.
// Reference items by scoped name, e.g. devicePkg::devReqT.

`default_nettype none

package devicePkg;

    // Request from a bridge to a device, word addressed
    typedef struct packed {
        logic [29:0] addr;
        logic [31:0] wData;
        logic we;
    } devReqT;

    // Word offset inside a timer window
    typedef enum logic [1:0] {
        regCtrl = 2'd0,
        regPreset = 2'd1,
        regCount = 2'd2
    } timerRegE;

    // One-shot stops at zero and holds its interrupt;
    // reload restarts from preset and pulses it
    typedef enum logic [1:0] {
        modeOneShot = 2'd0,
        modeReload = 2'd1
    } timerModeE;

    // Control word, bits above 3 read as zero
    typedef struct packed {
        logic irqMask;
        timerModeE mode;
        logic enable;
    } timerCtrlT;

    // Timer FSM
    typedef enum logic [1:0] {
        idle,
        load,
        counting,
        expired
    } timerStateE;

endpackage

`default_nettype wire

/* northBridge.sv */
// CPU-side bridge of the data bus.
// Sends data-window traffic to the data memory and timer traffic to the
// south bridge, then returns the matching read data in the same cycle.

`timescale 1ns/100ps
`default_nettype none

module northBridge (
    input busMapPkg::cpuReqT cpuReq,
    output logic [31:0] rData,
    // Data memory side
    output busMapPkg::cpuReqT dmReq,
    input logic [31:0] dmRData,
    // South bridge side
    output devicePkg::devReqT sbReq,
    input logic [31:0] sbRData
);

    busMapPkg::regionE region;
    logic inDevice;

    // Address classification
    always_comb begin
        if (busMapPkg::inWindow(cpuReq.addr, busMapPkg::DataStart, busMapPkg::DataEnd)) begin
            region = busMapPkg::regionData;
        end else if (busMapPkg::inWindow(cpuReq.addr, busMapPkg::Timer0Start,
                                         busMapPkg::Timer0End)) begin
            region = busMapPkg::regionTimer0;
        end else if (busMapPkg::inWindow(cpuReq.addr, busMapPkg::Timer1Start,
                                         busMapPkg::Timer1End)) begin
            region = busMapPkg::regionTimer1;
        end else begin
            region = busMapPkg::regionNone;
        end
    end

    // Either timer; the south bridge picks which one
    assign inDevice = (region == busMapPkg::regionTimer0) ||
                      (region == busMapPkg::regionTimer1);

    // Byte enables pass only inside the data window
    assign dmReq.pc = cpuReq.pc;
    assign dmReq.addr = cpuReq.addr;
    assign dmReq.wData = cpuReq.wData;
    assign dmReq.we = (region == busMapPkg::regionData) ? cpuReq.we : 4'b0000;

    // Devices take full-word writes only
    assign sbReq.addr = cpuReq.addr[31:2];
    assign sbReq.wData = cpuReq.wData;
    assign sbReq.we = inDevice && (&cpuReq.we);

    always_comb begin
        case (region)
            busMapPkg::regionData: rData = dmRData;
            busMapPkg::regionTimer0,
            busMapPkg::regionTimer1: rData = sbRData;
            default: rData = '0;
        endcase
    end

endmodule

`default_nettype wire

/* southBridge.sv */
// Device-side bridge of the data bus.
// Splits south bridge traffic between the two timers, returns the read
// data of the addressed timer and builds the hardware interrupt vector.

`timescale 1ns/100ps
`default_nettype none

module southBridge (
    input devicePkg::devReqT sbReq,
    output logic [31:0] rData,
    // Timer side
    output devicePkg::devReqT timer0Req,
    output devicePkg::devReqT timer1Req,
    input logic [31:0] timer0RData,
    input logic [31:0] timer1RData,
    // Interrupt sources
    input logic timer0Irq,
    input logic timer1Irq,
    input logic extInt,
    output logic [7:2] hwInt
);

    busMapPkg::regionE region;
    logic [31:0] byteAddr;

    // Windows are kept in bytes
    assign byteAddr = {sbReq.addr, 2'b00};

    always_comb begin
        if (busMapPkg::inWindow(byteAddr, busMapPkg::Timer0Start, busMapPkg::Timer0End)) begin
            region = busMapPkg::regionTimer0;
        end else if (busMapPkg::inWindow(byteAddr, busMapPkg::Timer1Start,
                                         busMapPkg::Timer1End)) begin
            region = busMapPkg::regionTimer1;
        end else begin
            region = busMapPkg::regionNone;
        end
    end

    // Address and data go to both timers, the strobe to one
    assign timer0Req.addr = sbReq.addr;
    assign timer0Req.wData = sbReq.wData;
    assign timer0Req.we = sbReq.we && (region == busMapPkg::regionTimer0);

    assign timer1Req.addr = sbReq.addr;
    assign timer1Req.wData = sbReq.wData;
    assign timer1Req.we = sbReq.we && (region == busMapPkg::regionTimer1);

    always_comb begin
        case (region)
            busMapPkg::regionTimer0: rData = timer0RData;
            busMapPkg::regionTimer1: rData = timer1RData;
            default: rData = '0;
        endcase
    end

    // Bits 7:5 have no source
    assign hwInt = {3'b000, extInt, timer1Irq, timer0Irq};

endmodule

`default_nettype wire

/* dataMemory.sv */
// Word-organized data RAM behind the north bridge.
// Byte lanes are written at the clock edge, reads are combinational.
// DataWords sets the depth; addresses wrap modulo the depth.

`timescale 1ns/100ps
`default_nettype none

module dataMemory #(
    parameter int DataWords = 3072
) (
    input logic clk,
    input logic reset,
    input busMapPkg::cpuReqT dmReq,
    output logic [31:0] rData
);

    localparam int IndexBits = (DataWords > 1) ? $clog2(DataWords) : 1;

    logic [31:0] mem [DataWords];
    logic [IndexBits-1:0] wordIndex;

    // Word index from the byte address
    assign wordIndex = IndexBits'(dmReq.addr[31:2] % DataWords);

    // Contents survive reset, but no write lands while it is held
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmReq.we[lane]) begin
                    mem[wordIndex][8*lane +: 8] <= dmReq.wData[8*lane +: 8];
                end
            end
        end
    end

    assign rData = mem[wordIndex];

endmodule

`default_nettype wire

/* countTimer.sv */
// Programmable countdown timer on the device bus.
// Registers: ctrl at offset 0, preset at 1, count at 2 (read only).
// A ctrl write with enable set loads preset and starts the countdown;
// irq follows irqMask while the FSM is in expired.

`timescale 1ns/100ps
`default_nettype none

module countTimer (
    input logic clk,
    input logic reset,
    input devicePkg::devReqT req,
    output logic [31:0] rData,
    output logic irq
);

    localparam int CtrlBits = $bits(devicePkg::timerCtrlT);

    devicePkg::timerCtrlT ctrl;
    devicePkg::timerCtrlT ctrlNew;
    devicePkg::timerStateE state;
    devicePkg::timerRegE regSel;
    logic [31:0] preset;
    logic [31:0] count;
    logic wrCtrl;
    logic wrPreset;
    logic isReload;

    assign regSel = devicePkg::timerRegE'(req.addr[1:0]);
    assign wrCtrl = req.we && (regSel == devicePkg::regCtrl);
    assign wrPreset = req.we && (regSel == devicePkg::regPreset);
    assign ctrlNew = devicePkg::timerCtrlT'(req.wData[CtrlBits-1:0]);
    assign isReload = (ctrl.mode == devicePkg::modeReload);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
            preset <= '0;
            count <= '0;
            state <= devicePkg::idle;
        end else begin
            if (wrPreset) begin
                preset <= req.wData;
            end

            if (wrCtrl) begin
                // Any ctrl write restarts the FSM
                ctrl <= ctrlNew;
                state <= ctrlNew.enable ? devicePkg::load : devicePkg::idle;
            end else begin
                case (state)
                    devicePkg::load: begin
                        // Zero preset keeps the timer parked
                        if (preset == '0) begin
                            state <= devicePkg::idle;
                        end else begin
                            count <= preset;
                            state <= devicePkg::counting;
                        end
                    end
                    devicePkg::counting: begin
                        count <= count - 32'd1;
                        if (count == 32'd1) begin
                            state <= devicePkg::expired;
                            if (!isReload) begin
                                ctrl.enable <= 1'b0;
                            end
                        end
                    end
                    devicePkg::expired: begin
                        // One-shot holds here until the next ctrl write
                        if (isReload) begin
                            if (preset == '0) begin
                                state <= devicePkg::idle;
                            end else begin
                                count <= preset;
                                state <= devicePkg::counting;
                            end
                        end
                    end
                    default: begin
                        state <= devicePkg::idle;
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (regSel)
            devicePkg::regCtrl: rData = {{(32 - CtrlBits){1'b0}}, ctrl};
            devicePkg::regPreset: rData = preset;
            devicePkg::regCount: rData = count;
            default: rData = '0;
        endcase
    end

    assign irq = ctrl.irqMask && (state == devicePkg::expired);

endmodule

`default_nettype wire

/* busSubsystem.sv */
// Top level of the data bus: north bridge, data memory, south bridge
// and two countdown timers. Drive cpuReq once per cycle; rData is valid
// in the same cycle and hwInt carries the interrupt vector.

`timescale 1ns/100ps
`default_nettype none

module busSubsystem #(
    parameter int DataWords = 3072
) (
    input logic clk,
    input logic reset,
    input busMapPkg::cpuReqT cpuReq,
    input logic extInt,
    output logic [31:0] rData,
    output logic [7:2] hwInt
);

    busMapPkg::cpuReqT dmReq;
    devicePkg::devReqT sbReq;
    devicePkg::devReqT timer0Req;
    devicePkg::devReqT timer1Req;
    logic [31:0] dmRData;
    logic [31:0] sbRData;
    logic [31:0] timer0RData;
    logic [31:0] timer1RData;
    logic timer0Irq;
    logic timer1Irq;

    northBridge north (
        .cpuReq(cpuReq),
        .rData(rData),
        .dmReq(dmReq),
        .dmRData(dmRData),
        .sbReq(sbReq),
        .sbRData(sbRData)
    );

    dataMemory #(
        .DataWords(DataWords)
    ) dataMem (
        .clk(clk),
        .reset(reset),
        .dmReq(dmReq),
        .rData(dmRData)
    );

    southBridge south (
        .sbReq(sbReq),
        .rData(sbRData),
        .timer0Req(timer0Req),
        .timer1Req(timer1Req),
        .timer0RData(timer0RData),
        .timer1RData(timer1RData),
        .timer0Irq(timer0Irq),
        .timer1Irq(timer1Irq),
        .extInt(extInt),
        .hwInt(hwInt)
    );

    countTimer timer0 (
        .clk(clk),
        .reset(reset),
        .req(timer0Req),
        .rData(timer0RData),
        .irq(timer0Irq)
    );

    countTimer timer1 (
        .clk(clk),
        .reset(reset),
        .req(timer1Req),
        .rData(timer1RData),
        .irq(timer1Irq)
    );

endmodule

`default_nettype wire

/* busSubsystem_assertions.sv */
// Concurrent checks on the data bus top level, attached with bind.
// Covers strobe routing, data memory gating, the unused interrupt bits
// and the one-shot interrupt hold of both timers.

`timescale 1ns/100ps
`default_nettype none

module busSubsystem_assertions (
    input logic clk,
    input logic reset,
    input busMapPkg::cpuReqT cpuReq,
    input busMapPkg::cpuReqT dmReq,
    input devicePkg::devReqT timer0Req,
    input devicePkg::devReqT timer1Req,
    input logic [7:2] hwInt,
    input devicePkg::timerStateE timer0State,
    input devicePkg::timerCtrlT timer0Ctrl,
    input logic timer0Irq,
    input devicePkg::timerStateE timer1State,
    input devicePkg::timerCtrlT timer1Ctrl,
    input logic timer1Irq
);

    logic ctrlWrite0;
    logic ctrlWrite1;
    logic held0;
    logic held1;

    assign ctrlWrite0 = timer0Req.we && (timer0Req.addr[1:0] == 2'd0);
    assign ctrlWrite1 = timer1Req.we && (timer1Req.addr[1:0] == 2'd0);

    // Expired one-shot with the interrupt unmasked
    assign held0 = (timer0State == devicePkg::expired) && timer0Ctrl.irqMask &&
                   (timer0Ctrl.mode == devicePkg::modeOneShot);
    assign held1 = (timer1State == devicePkg::expired) && timer1Ctrl.irqMask &&
                   (timer1Ctrl.mode == devicePkg::modeOneShot);

    strobeOneTimer: assert property (@(posedge clk) disable iff (reset)
        !(timer0Req.we && timer1Req.we))
        else $error("Device write strobe reached both timers");

    dataWeGated: assert property (@(posedge clk) disable iff (reset)
        !busMapPkg::inWindow(cpuReq.addr, busMapPkg::DataStart, busMapPkg::DataEnd)
        |-> (dmReq.we == 4'b0000))
        else $error("Data memory byte enables set outside the data window");

    unusedIntLow: assert property (@(posedge clk) disable iff (reset)
        hwInt[7:5] == 3'b000)
        else $error("Interrupt bits 7:5 are not zero");

    oneShotHold0: assert property (@(posedge clk) disable iff (reset)
        (held0 && !ctrlWrite0) |=> timer0Irq)
        else $error("Timer 0 one-shot interrupt dropped without a ctrl write");

    oneShotHold1: assert property (@(posedge clk) disable iff (reset)
        (held1 && !ctrlWrite1) |=> timer1Irq)
        else $error("Timer 1 one-shot interrupt dropped without a ctrl write");

endmodule

bind busSubsystem busSubsystem_assertions busChecks (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .dmReq(dmReq),
    .timer0Req(timer0Req),
    .timer1Req(timer1Req),
    .hwInt(hwInt),
    .timer0State(timer0.state),
    .timer0Ctrl(timer0.ctrl),
    .timer0Irq(timer0Irq),
    .timer1State(timer1.state),
    .timer1Ctrl(timer1.ctrl),
    .timer1Irq(timer1Irq)
);

`default_nettype wire

/* busSubsystem_tb.sv */
// Testbench for the data bus subsystem.
// Replays the operations in busVectors_input.txt, then runs a random
// memory fill with readback, a reload-mode pass on timer 1 and a check
// that full-word writes beside the timer windows are dropped.

`timescale 1ns/100ps
`default_nettype none

module busSubsystem_tb;

    localparam int DataWords = 3072;
    localparam int WaitLimit = 64;
    localparam int MaxLines = 256;
    localparam int FillWords = 64;
    localparam logic [31:0] IdleAddr = 32'hFFFF_FF00;
    localparam logic [31:0] TaskPc = 32'h0040_2000;

    logic clk;
    logic reset;
    busMapPkg::cpuReqT cpuReq;
    logic extInt;
    logic [31:0] rData;
    logic [7:2] hwInt;
    int mismatches;
    int timeouts;
    int otherErrors;

    busSubsystem #(
        .DataWords(DataWords)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .cpuReq(cpuReq),
        .extInt(extInt),
        .rData(rData),
        .hwInt(hwInt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic expectValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // One bus cycle sampled mid-cycle where outputs are settled
    task automatic busCycle(input logic [31:0] pc, input logic [31:0] addr,
                            input logic [31:0] wData, input logic [3:0] we);
        @(posedge clk);
        cpuReq <= {pc, addr, wData, we};
        @(negedge clk);
    endtask

    task automatic driveExtInt(input logic [31:0] pc, input logic level);
        @(posedge clk);
        extInt <= level;
        cpuReq <= {pc, IdleAddr, 32'h0, 4'h0};
        @(negedge clk);
    endtask

    task automatic runVectorFile();
        int fd;
        int fields;
        int lineCount;
        string lineText;
        logic [7:0] op;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] wData;
        logic [3:0] we;
        logic [31:0] expRData;
        logic [5:0] expHwInt;
        fd = $fopen("busVectors_input.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open the vector file busVectors_input.txt");
            return;
        end
        lineCount = 0;
        while (!$feof(fd) && lineCount < MaxLines) begin
            lineCount++;
            void'($fgets(lineText, fd));
            fields = $sscanf(lineText, "%s %h %h %h %h %h %h",
                             op, pc, addr, wData, we, expRData, expHwInt);
            // Comment and blank lines do not parse to seven fields
            if (fields == 7) begin
                case (op)
                    "W": busCycle(pc, addr, wData, we);
                    "R": begin
                        busCycle(pc, addr, 32'h0, 4'h0);
                        expectValue("rData", expRData, rData);
                        expectValue("hwInt", 32'(expHwInt), 32'(hwInt));
                    end
                    "I": begin
                        for (int i = 0; i < int'(wData); i++) begin
                            busCycle(pc, addr, 32'h0, 4'h0);
                        end
                        expectValue("hwInt", 32'(expHwInt), 32'(hwInt));
                    end
                    "E": begin
                        driveExtInt(pc, wData[0]);
                        expectValue("hwInt", 32'(expHwInt), 32'(hwInt));
                    end
                    default: begin
                        otherErrors++;
                        $display("Unknown operation on line %0d of the vector file", lineCount);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // Spread over the window with a stride coprime to the depth
    task automatic fillAndReadBack();
        logic [31:0] wordAddr [FillWords];
        logic [31:0] wordData [FillWords];
        for (int i = 0; i < FillWords; i++) begin
            wordAddr[i] = 32'((i * 191) % DataWords) << 2;
            wordData[i] = $urandom();
            busCycle(TaskPc, wordAddr[i], wordData[i], 4'hF);
        end
        for (int i = 0; i < FillWords; i++) begin
            busCycle(TaskPc, wordAddr[i], 32'h0, 4'h0);
            expectValue("rData", wordData[i], rData);
        end
    endtask

    task automatic checkReload(input logic [31:0] presetVal);
        int waited;
        int gap;
        logic seen;
        busCycle(TaskPc, 32'h0000_7F14, presetVal, 4'hF);
        // irqMask, reload mode, enable
        busCycle(TaskPc, 32'h0000_7F10, 32'h0000_000B, 4'hF);
        waited = 0;
        while (!hwInt[3] && waited < WaitLimit) begin
            busCycle(TaskPc, 32'h0000_7F18, 32'h0, 4'h0);
            waited++;
        end
        if (!hwInt[3]) begin
            timeouts++;
            $display("Timed out waiting for the first timer 1 reload interrupt");
        end else begin
            for (int p = 0; p < 3; p++) begin
                gap = 0;
                seen = 1'b0;
                while (!seen && gap < WaitLimit) begin
                    busCycle(TaskPc, 32'h0000_7F18, 32'h0, 4'h0);
                    gap++;
                    if (hwInt[3]) begin
                        seen = 1'b1;
                    end else begin
                        assert (rData >= 32'd1 && rData <= presetVal) else begin
                            mismatches++;
                            $display("FAIL time=%0t signal=rData expected=1..%0d actual=%0d",
                                     $time, presetVal, rData);
                        end
                    end
                end
                if (!seen) begin
                    timeouts++;
                    $display("Timed out waiting for timer 1 reload interrupt %0d", p + 2);
                end else begin
                    expectValue("hwInt[3] interval", presetVal + 32'd1, 32'(gap));
                end
            end
        end
        busCycle(TaskPc, 32'h0000_7F10, 32'h0, 4'hF);
    endtask

    // Both ctrl registers hold zero here; these addresses alias offset 0
    task automatic probeOffWindowWrites();
        busCycle(TaskPc, 32'h0000_7EF0, 32'h0000_000F, 4'hF);
        busCycle(TaskPc, 32'h0000_7F20, 32'h0000_000F, 4'hF);
        busCycle(TaskPc, 32'h0000_7F00, 32'h0, 4'h0);
        expectValue("rData", 32'h0, rData);
        busCycle(TaskPc, 32'h0000_7F10, 32'h0, 4'h0);
        expectValue("rData", 32'h0, rData);
    endtask

    initial begin
        void'($urandom(32'hb5d0_a08e));
        mismatches = 0;
        timeouts = 0;
        otherErrors = 0;
        reset = 1'b1;
        extInt = 1'b0;
        cpuReq = {32'h0, IdleAddr, 32'h0, 4'h0};
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        runVectorFile();
        fillAndReadBack();
        checkReload(32'd4);
        probeOffWindowWrites();

        $display("Errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatches, timeouts, otherErrors);
        if (mismatches == 0 && timeouts == 0 && otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* busVectors_input.txt */
# op pc addr wData we expRData expHwInt (hex; expHwInt holds hwInt[7:2])
# W write, R read and check, I idle wData cycles then check hwInt, E extInt = wData[0]
W 00400000 00000100 11223344 f 00000000 00
R 00400004 00000100 00000000 0 11223344 00
W 00400008 00000100 aabbccdd 5 00000000 00
R 0040000c 00000100 00000000 0 11bb33dd 00
W 00400010 00001000 cafef00d f 00000000 00
W 00400014 00004000 deadbeef f 00000000 00
R 00400018 00001000 00000000 0 cafef00d 00
R 0040001c 00004000 00000000 0 00000000 00
R 00400020 00007f0c 00000000 0 00000000 00
W 00400024 00007f04 00000007 f 00000000 00
W 00400028 00007f04 12345678 7 00000000 00
R 0040002c 00007f04 00000000 0 00000007 00
W 00400030 00007f0c 00000055 f 00000000 00
W 00400034 00007f20 00000066 f 00000000 00
R 00400038 00007f14 00000000 0 00000000 00
W 0040003c 00007f00 fffffff8 f 00000000 00
R 00400040 00007f00 00000000 0 00000008 00
W 00400044 00007f08 00000099 f 00000000 00
R 00400048 00007f08 00000000 0 00000000 00
W 0040004c 00007f04 00000005 f 00000000 00
W 00400050 00007f00 00000009 f 00000000 00
I 00400054 ffffff00 00000006 0 00000000 00
I 00400058 ffffff00 00000001 0 00000000 01
I 0040005c ffffff00 00000003 0 00000000 01
R 00400060 00007f00 00000000 0 00000008 01
W 00400064 00007f00 00000000 f 00000000 00
I 00400068 ffffff00 00000001 0 00000000 00
W 0040006c 00007f14 00000003 f 00000000 00
W 00400070 00007f10 00000009 f 00000000 00
I 00400074 ffffff00 00000004 0 00000000 00
I 00400078 ffffff00 00000001 0 00000000 02
R 0040007c 00007f10 00000000 0 00000008 02
W 00400080 00007f10 00000000 f 00000000 00
I 00400084 ffffff00 00000001 0 00000000 00
W 00400088 00007f10 00000001 f 00000000 00
I 0040008c ffffff00 0000000a 0 00000000 00
R 00400090 00007f10 00000000 0 00000000 00
E 00400094 ffffff00 00000001 0 00000000 04
R 00400098 00007f14 00000000 0 00000003 04
E 0040009c ffffff00 00000000 0 00000000 00

/* busSubsystem.f */
busMapPkg.sv
devicePkg.sv
northBridge.sv
southBridge.sv
dataMemory.sv
countTimer.sv
busSubsystem.sv
busSubsystem_assertions.sv
busSubsystem_tb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the data bus testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module busSubsystem_tb \
    -f busSubsystem.f \
    -o busSubsystem_sim

simStatus=0
./obj_dir/busSubsystem_sim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log || [ "$simStatus" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
